/* Makefile */
# Verilator simulation of the pipelined MIPS core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --top-module tb_mips_top -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_mips_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* common/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath widths
`define MIPS_WORD_BITS        32
`define MIPS_REG_BITS         5
`define MIPS_IMM_BITS         16

// Instruction field positions
`define MIPS_OPCODE_LSB       26
`define MIPS_OPCODE_BITS      6
`define MIPS_RS_LSB           21
`define MIPS_RT_LSB           16
`define MIPS_RD_LSB           11
`define MIPS_SHAMT_LSB        6
`define MIPS_FUNCT_BITS       6

// Instruction memory depth in words
`define MIPS_IMEM_WORDS       64
`define MIPS_IMEM_ADDR_BITS   6
`define MIPS_RESET_PC         32'h0000_0000

`endif

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    `include "mips_consts.svh"

    typedef logic [`MIPS_WORD_BITS-1:0] word_t;
    typedef logic [`MIPS_REG_BITS-1:0]  reg_addr_t;
    typedef logic [`MIPS_IMM_BITS-1:0]  imm_t;

    // MIPS32 primary opcodes handled by the core
    typedef enum logic [`MIPS_OPCODE_BITS-1:0] {
        op_rtype = 6'h00,
        op_addiu = 6'h09,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f
    } opcode_e;

    // R-type function codes
    typedef enum logic [`MIPS_FUNCT_BITS-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        imm_sign,
        imm_zero
    } imm_mode_e;

    typedef enum logic {
        fwd_reg,
        fwd_wb
    } fwd_sel_e;

endpackage

`default_nettype wire

/* decode/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module control_unit (
    input  wire mips_pkg::word_t  i_instr,
    output mips_pkg::alu_op_e     o_alu_op,
    output logic                  o_alu_src_imm,
    output logic                  o_reg_write,
    output logic                  o_dst_rd,
    output mips_pkg::imm_mode_e   o_imm_mode
);
    import mips_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t dst;
    logic      supported;

    assign opcode = opcode_e'(i_instr[`MIPS_OPCODE_LSB +: `MIPS_OPCODE_BITS]);
    assign funct  = funct_e'(i_instr[0 +: `MIPS_FUNCT_BITS]);

    always_comb begin
        o_alu_op      = alu_add;
        o_alu_src_imm = 1'b0;
        o_dst_rd      = 1'b0;
        o_imm_mode    = imm_zero;
        supported     = 1'b1;
        case (opcode)
            op_rtype: begin
                o_dst_rd = 1'b1;
                case (funct)
                    fn_sll:  o_alu_op = alu_sll;
                    fn_srl:  o_alu_op = alu_srl;
                    fn_addu: o_alu_op = alu_add;
                    fn_subu: o_alu_op = alu_sub;
                    fn_and:  o_alu_op = alu_and;
                    fn_or:   o_alu_op = alu_or;
                    fn_xor:  o_alu_op = alu_xor;
                    fn_slt:  o_alu_op = alu_slt;
                    default: supported = 1'b0;
                endcase
            end
            op_addiu: begin
                o_alu_op      = alu_add;
                o_alu_src_imm = 1'b1;
                o_imm_mode    = imm_sign;
            end
            op_andi: begin
                o_alu_op      = alu_and;
                o_alu_src_imm = 1'b1;
            end
            op_ori: begin
                o_alu_op      = alu_or;
                o_alu_src_imm = 1'b1;
            end
            op_xori: begin
                o_alu_op      = alu_xor;
                o_alu_src_imm = 1'b1;
            end
            op_lui: begin
                o_alu_op      = alu_lui;
                o_alu_src_imm = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    // Writes to register zero are dropped here
    assign dst = o_dst_rd ? i_instr[`MIPS_RD_LSB +: `MIPS_REG_BITS]
                          : i_instr[`MIPS_RT_LSB +: `MIPS_REG_BITS];
    assign o_reg_write = supported && (dst != '0);

endmodule

`default_nettype wire

/* decode/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module register_file (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire mips_pkg::word_t      i_instr,
    input  wire                       i_we,
    input  wire mips_pkg::reg_addr_t  i_waddr,
    input  wire mips_pkg::word_t      i_wdata,
    input  wire mips_pkg::reg_addr_t  i_dbg_sel,
    output mips_pkg::word_t           o_rs_data,
    output mips_pkg::word_t           o_rt_data,
    output mips_pkg::word_t           o_dbg_data
);
    import mips_pkg::*;

    word_t regs [0:(1 << `MIPS_REG_BITS)-1];

    // Write-through so a same-cycle write is seen by the reader
    function automatic word_t read_reg(input reg_addr_t addr, input logic we,
                                       input reg_addr_t waddr, input word_t wdata,
                                       input word_t stored);
        if (addr == '0) begin
            return '0;
        end else if (we && (waddr == addr)) begin
            return wdata;
        end
        return stored;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < (1 << `MIPS_REG_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    always_comb begin
        o_rs_data  = read_reg(i_instr[`MIPS_RS_LSB +: `MIPS_REG_BITS], i_we, i_waddr, i_wdata,
                              regs[i_instr[`MIPS_RS_LSB +: `MIPS_REG_BITS]]);
        o_rt_data  = read_reg(i_instr[`MIPS_RT_LSB +: `MIPS_REG_BITS], i_we, i_waddr, i_wdata,
                              regs[i_instr[`MIPS_RT_LSB +: `MIPS_REG_BITS]]);
        o_dbg_data = read_reg(i_dbg_sel, i_we, i_waddr, i_wdata, regs[i_dbg_sel]);
    end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module execute_stage (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_step,
    input  wire mips_pkg::word_t       i_instr,
    input  wire mips_pkg::word_t       i_rs_data,
    input  wire mips_pkg::word_t       i_rt_data,
    input  wire mips_pkg::alu_op_e     i_alu_op,
    input  wire                        i_alu_src_imm,
    input  wire                        i_reg_write,
    input  wire                        i_dst_rd,
    input  wire mips_pkg::imm_mode_e   i_imm_mode,
    output logic                       o_wb_we,
    output mips_pkg::reg_addr_t        o_wb_addr,
    output mips_pkg::word_t            o_wb_data
);
    import mips_pkg::*;

    word_t     idex_instr;
    word_t     idex_rs_data;
    word_t     idex_rt_data;
    alu_op_e   idex_alu_op;
    logic      idex_alu_src_imm;
    logic      idex_reg_write;
    logic      idex_dst_rd;
    imm_mode_e idex_imm_mode;

    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
    imm_t      imm;
    word_t     imm_ext;
    fwd_sel_e  sel_a;
    fwd_sel_e  sel_b;
    word_t     op_a;
    word_t     op_b_reg;
    word_t     op_b;
    logic [`MIPS_REG_BITS-1:0] shamt;
    word_t     alu_result;

    // ID/EX controls
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idex_alu_op      <= alu_add;
            idex_alu_src_imm <= 1'b0;
            idex_reg_write   <= 1'b0;
            idex_dst_rd      <= 1'b0;
            idex_imm_mode    <= imm_zero;
        end else if (i_step) begin
            idex_alu_op      <= i_alu_op;
            idex_alu_src_imm <= i_alu_src_imm;
            idex_reg_write   <= i_reg_write;
            idex_dst_rd      <= i_dst_rd;
            idex_imm_mode    <= i_imm_mode;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            idex_instr   <= i_instr;
            idex_rs_data <= i_rs_data;
            idex_rt_data <= i_rt_data;
        end
    end

    assign rs    = idex_instr[`MIPS_RS_LSB +: `MIPS_REG_BITS];
    assign rt    = idex_instr[`MIPS_RT_LSB +: `MIPS_REG_BITS];
    assign dst   = idex_dst_rd ? idex_instr[`MIPS_RD_LSB +: `MIPS_REG_BITS] : rt;
    assign imm   = idex_instr[`MIPS_IMM_BITS-1:0];
    assign shamt = idex_instr[`MIPS_SHAMT_LSB +: `MIPS_REG_BITS];

    assign imm_ext = (idex_imm_mode == imm_sign)
                   ? {{(`MIPS_WORD_BITS-`MIPS_IMM_BITS){imm[`MIPS_IMM_BITS-1]}}, imm}
                   : {{(`MIPS_WORD_BITS-`MIPS_IMM_BITS){1'b0}}, imm};

    forwarding_unit u_fwd (
        .i_rs      (rs),
        .i_rt      (rt),
        .i_wb_addr (o_wb_addr),
        .i_wb_we   (o_wb_we),
        .o_sel_a   (sel_a),
        .o_sel_b   (sel_b)
    );

    assign op_a     = (sel_a == fwd_wb) ? o_wb_data : idex_rs_data;
    assign op_b_reg = (sel_b == fwd_wb) ? o_wb_data : idex_rt_data;
    assign op_b     = idex_alu_src_imm ? imm_ext : op_b_reg;

    always_comb begin
        case (idex_alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sll: alu_result = op_b << shamt;
            alu_srl: alu_result = op_b >> shamt;
            // Zero-extended immediate moved to the upper half
            alu_lui: alu_result = op_b << `MIPS_IMM_BITS;
            default: alu_result = '0;
        endcase
    end

    // EX/WB register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_we   <= 1'b0;
            o_wb_addr <= '0;
        end else if (i_step) begin
            o_wb_we   <= idex_reg_write;
            o_wb_addr <= dst;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_wb_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* execute/forwarding_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module forwarding_unit (
    input  wire mips_pkg::reg_addr_t  i_rs,
    input  wire mips_pkg::reg_addr_t  i_rt,
    input  wire mips_pkg::reg_addr_t  i_wb_addr,
    input  wire                       i_wb_we,
    output mips_pkg::fwd_sel_e        o_sel_a,
    output mips_pkg::fwd_sel_e        o_sel_b
);
    import mips_pkg::*;

    // Write enable is never set for register zero
    always_comb begin
        o_sel_a = fwd_reg;
        o_sel_b = fwd_reg;
        if (i_wb_we && (i_wb_addr == i_rs)) begin
            o_sel_a = fwd_wb;
        end
        if (i_wb_we && (i_wb_addr == i_rt)) begin
            o_sel_b = fwd_wb;
        end
    end

endmodule

`default_nettype wire

/* fetch/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module fetch_stage (
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    input  wire                              i_step,
    input  wire                              i_imem_we,
    input  wire [`MIPS_IMEM_ADDR_BITS-1:0]   i_imem_addr,
    input  wire mips_pkg::word_t             i_imem_data,
    output mips_pkg::word_t                  o_pc,
    output mips_pkg::word_t                  o_instr
);
    import mips_pkg::*;

    word_t                          imem [0:`MIPS_IMEM_WORDS-1];
    logic [`MIPS_IMEM_ADDR_BITS-1:0] pc_word;
    word_t                          pc_next;

    // Word index of the byte PC wraps over the memory depth
    assign pc_word = o_pc[`MIPS_IMEM_ADDR_BITS+1:2];
    assign pc_next = word_t'({pc_word + 1'b1, 2'b00});

    // Load port works regardless of i_step
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `MIPS_RESET_PC;
        end else if (i_step) begin
            o_pc <= pc_next;
        end
    end

    // IF/ID register resets to a nop
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr <= '0;
        end else if (i_step) begin
            o_instr <= imem[pc_word];
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/control_unit.sv
decode/register_file.sv
execute/forwarding_unit.sv
execute/execute_stage.sv
hw/mips_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_top.sv

/* hw/mips_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_top (
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    input  wire                              i_step,
    input  wire                              i_imem_we,
    input  wire [`MIPS_IMEM_ADDR_BITS-1:0]   i_imem_addr,
    input  wire mips_pkg::word_t             i_imem_data,
    input  wire mips_pkg::reg_addr_t         i_reg_sel,
    output mips_pkg::word_t                  o_pc,
    output mips_pkg::word_t                  o_reg_data
);
    import mips_pkg::*;

    word_t     ifid_instr;
    word_t     rs_data;
    word_t     rt_data;
    alu_op_e   ctl_alu_op;
    logic      ctl_alu_src_imm;
    logic      ctl_reg_write;
    logic      ctl_dst_rd;
    imm_mode_e ctl_imm_mode;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    fetch_stage u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (i_step),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_pc        (o_pc),
        .o_instr     (ifid_instr)
    );

    control_unit u_control (
        .i_instr       (ifid_instr),
        .o_alu_op      (ctl_alu_op),
        .o_alu_src_imm (ctl_alu_src_imm),
        .o_reg_write   (ctl_reg_write),
        .o_dst_rd      (ctl_dst_rd),
        .o_imm_mode    (ctl_imm_mode)
    );

    register_file u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_instr    (ifid_instr),
        .i_we       (wb_we),
        .i_waddr    (wb_addr),
        .i_wdata    (wb_data),
        .i_dbg_sel  (i_reg_sel),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_reg_data)
    );

    execute_stage u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_step        (i_step),
        .i_instr       (ifid_instr),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_alu_op      (ctl_alu_op),
        .i_alu_src_imm (ctl_alu_src_imm),
        .i_reg_write   (ctl_reg_write),
        .i_dst_rd      (ctl_dst_rd),
        .i_imm_mode    (ctl_imm_mode),
        .o_wb_we       (wb_we),
        .o_wb_addr     (wb_addr),
        .o_wb_data     (wb_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset held low for the first clock edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_mips_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module tb_mips_top;
    import mips_pkg::*;

    localparam int PROG_LEN       = 40;
    localparam int DRAIN_STEPS    = PROG_LEN + 3;
    localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
    localparam int DRIVE_DELAY    = 1;
    localparam logic [31:0] SEED  = 32'h4197;

    // Standard MIPS32 encodings
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic                            clk;
    logic                            rst_n;
    logic                            step;
    logic                            imem_we;
    logic [`MIPS_IMEM_ADDR_BITS-1:0] imem_addr;
    word_t                           imem_data;
    reg_addr_t                       reg_sel;
    word_t                           pc;
    word_t                           reg_data;

    word_t prog_mem [0:PROG_LEN-1];
    word_t model_regs [0:31];
    word_t exp_pc;
    logic  step_q;
    int    cycles;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    mips_top dut0 (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_step      (step),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_reg_sel   (reg_sel),
        .o_pc        (pc),
        .o_reg_data  (reg_data)
    );

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_pc(input word_t expected);
        if (pc !== expected) begin
            $display("** Error at %0d ns: o_pc got %h expected %h", $time, pc, expected);
            abort_run();
        end
    endtask

    task automatic check_reg(input reg_addr_t sel, input word_t expected);
        if (reg_data !== expected) begin
            $display("** Error at %0d ns: o_reg_data (r%0d) got %h expected %h",
                     $time, sel, reg_data, expected);
            abort_run();
        end
    endtask

    // PC wraps over the instruction memory in bytes
    function automatic word_t pc_after_step(input word_t cur);
        return (cur + 32'd4) % (`MIPS_IMEM_WORDS * 4);
    endfunction

    // Unused memory words get an unsupported opcode tagged with the address
    function automatic word_t fill_word(input logic [`MIPS_IMEM_ADDR_BITS-1:0] addr);
        return {6'h3f, 20'h00000, addr};
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        word_t       instr;
        r     = $urandom;
        rs    = {2'b00, r[2:0]};
        rt    = {2'b00, r[5:3]};
        rd    = {2'b00, r[8:6]};
        shamt = r[13:9];
        imm   = r[31:16];
        r     = $urandom;
        case (r[3:0])
            4'd0:    instr = {OP_RTYPE, 5'd0, rt, rd, shamt, FN_SLL};
            4'd1:    instr = {OP_RTYPE, 5'd0, rt, rd, shamt, FN_SRL};
            4'd2:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADDU};
            4'd3:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SUBU};
            4'd4:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_AND};
            4'd5:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_OR};
            4'd6:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_XOR};
            4'd7:    instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SLT};
            4'd8:    instr = {OP_ADDIU, rs, rt, imm};
            4'd9:    instr = {OP_ANDI, rs, rt, imm};
            4'd10:   instr = {OP_ORI, rs, rt, imm};
            4'd11:   instr = {OP_XORI, rs, rt, imm};
            4'd12:   instr = {OP_LUI, 5'd0, rt, imm};
            4'd13:   instr = {OP_ADDIU, rs, rt, imm};
            // A few words the core does not support
            4'd14:   instr = {OP_LW, rs, rt, imm};
            default: instr = {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADD};
        endcase
        return instr;
    endfunction

    // Sequential ISA model
    task automatic model_exec(input word_t instr);
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        logic [4:0] shamt;
        word_t     a;
        word_t     b;
        word_t     imm_s;
        word_t     imm_z;
        word_t     res;
        logic      wr;
        rs    = instr[25:21];
        rt    = instr[20:16];
        shamt = instr[10:6];
        a     = model_regs[rs];
        b     = model_regs[rt];
        imm_s = {{16{instr[15]}}, instr[15:0]};
        imm_z = {16'h0000, instr[15:0]};
        dst   = rt;
        res   = '0;
        wr    = 1'b1;
        case (instr[31:26])
            OP_RTYPE: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_SLL:  res = b << shamt;
                    FN_SRL:  res = b >> shamt;
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + imm_s;
            OP_ANDI:  res = a & imm_z;
            OP_ORI:   res = a | imm_z;
            OP_XORI:  res = a ^ imm_z;
            OP_LUI:   res = {instr[15:0], 16'h0000};
            default:  wr = 1'b0;
        endcase
        if (wr && (dst != 5'd0)) begin
            model_regs[dst] = res;
        end
    endtask

    // Inputs change just after the edge and outputs are checked at the falling edge
    task automatic tick(input logic s, input logic we,
                        input logic [`MIPS_IMEM_ADDR_BITS-1:0] addr,
                        input word_t data, input reg_addr_t sel);
        @(posedge clk);
        if (step_q) begin
            exp_pc = pc_after_step(exp_pc);
        end
        #(DRIVE_DELAY);
        step      = s;
        imem_we   = we;
        imem_addr = addr;
        imem_data = data;
        reg_sel   = sel;
        step_q    = s;
        @(negedge clk);
        check_pc(exp_pc);
    endtask

    task automatic read_back_regs();
        for (int r = 0; r < 32; r++) begin
            tick(1'b0, 1'b0, '0, '0, reg_addr_t'(r));
            check_reg(reg_addr_t'(r), model_regs[r]);
        end
    endtask

    task automatic load_program();
        word_t data;
        for (int a = 0; a < `MIPS_IMEM_WORDS; a++) begin
            data = (a < PROG_LEN) ? prog_mem[a] : fill_word(a[`MIPS_IMEM_ADDR_BITS-1:0]);
            tick(1'b0, 1'b1, a[`MIPS_IMEM_ADDR_BITS-1:0], data, '0);
        end
    endtask

    task automatic run_program();
        logic [31:0] r;
        logic        s;
        int          issued;
        issued = 0;
        while (issued < DRAIN_STEPS) begin
            r = $urandom;
            s = (r[1:0] != 2'b00);
            if (s) begin
                if (issued < PROG_LEN) begin
                    model_exec(prog_mem[issued]);
                end
                issued = issued + 1;
            end
            tick(s, 1'b0, '0, '0, '0);
        end
        // Last step lands on this edge
        tick(1'b0, 1'b0, '0, '0, '0);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("** Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        step      = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        reg_sel   = '0;
        step_q    = 1'b0;
        exp_pc    = '0;
        cycles    = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_mem[i] = random_instr();
        end
        @(posedge rst_n);
        read_back_regs();
        load_program();
        run_program();
        read_back_regs();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
